//--- compile.f
source/nice_isa_pkg.sv
source/nice_conv_pkg.sv
source/nice_ctrl.sv
source/nice_lsu.sv
source/conv_buffers.sv
source/conv_engine.sv
source/nice_conv_top.sv
bench/nice_conv_props.sv
bench/nice_conv_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := nice_conv_tb
FILELIST  := compile.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/nice_conv_tb.sv
// memory answers in command order; pass 1 adds random stalls, response delay and core back-pressure
`timescale 1ns/100ps

module nice_conv_tb;

  localparam int KERNEL_NUM   = 5;
  localparam int KERNEL_WIDTH = 3;
  localparam int IMAGE_WIDTH  = 14;
  localparam int OUT_WIDTH    = IMAGE_WIDTH - KERNEL_WIDTH + 1;
  localparam int KW2          = KERNEL_WIDTH * KERNEL_WIDTH;
  localparam int KERNEL_WORDS = KERNEL_NUM * KW2;
  localparam int IMAGE_WORDS  = IMAGE_WIDTH * IMAGE_WIDTH;
  localparam int RESULT_WORDS = KERNEL_NUM * OUT_WIDTH * OUT_WIDTH;
  // two passes of roughly 8000 cycles each with stalls at most doubling that
  localparam int CYCLE_LIMIT  = 40000;

  localparam logic [31:0] KERNEL_BASE = 32'h0000_1000;
  localparam logic [31:0] IMAGE_BASE  = 32'h0000_2000;
  localparam logic [31:0] RESULT_BASE = 32'h0001_0000;
  localparam logic [31:0] NO_ERR_ADDR = 32'hffff_fff0;

  logic                nice_clk;
  logic                nice_rst_n;
  logic                nice_active;
  logic                nice_mem_holdup;
  logic                nice_req_valid;
  logic                nice_req_ready;
  nice_isa_pkg::xlen_t nice_req_inst;
  nice_isa_pkg::addr_t nice_req_rs1;
  logic                nice_rsp_valid;
  logic                nice_rsp_ready;
  nice_isa_pkg::xlen_t nice_rsp_rdat;
  logic                nice_rsp_err;
  logic                nice_icb_cmd_valid;
  logic                nice_icb_cmd_ready;
  nice_isa_pkg::addr_t nice_icb_cmd_addr;
  logic                nice_icb_cmd_read;
  nice_isa_pkg::xlen_t nice_icb_cmd_wdata;
  logic [1:0]          nice_icb_cmd_size;
  logic                nice_icb_rsp_valid;
  logic                nice_icb_rsp_ready;
  nice_isa_pkg::xlen_t nice_icb_rsp_rdata;
  logic                nice_icb_rsp_err;

  logic [31:0] mem [logic [31:0]];
  logic [31:0] pend_addr [$];
  logic [31:0] err_addr;
  bit          stress;
  int          errors = 0;
  int          checks = 0;
  int          cycle_count = 0;

  nice_conv_top #(
    .KERNEL_NUM(KERNEL_NUM), .KERNEL_WIDTH(KERNEL_WIDTH), .IMAGE_WIDTH(IMAGE_WIDTH)
  ) uut (.*);

  bind nice_lsu nice_conv_props u_props (
    .nice_clk, .nice_rst_n, .nice_icb_cmd_valid, .nice_icb_cmd_ready,
    .nice_icb_cmd_addr, .nice_icb_cmd_read, .nice_icb_cmd_wdata,
    .nice_icb_cmd_size, .nice_icb_rsp_valid, .nice_icb_rsp_ready
  );

  initial begin
    nice_clk = 1'b0;
    forever #50 nice_clk = ~nice_clk;
  end

  always @(posedge nice_clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic logic [31:0] read_word(logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {addr[15:0], addr[31:16]} ^ 32'h6b2f_91c3;
  endfunction

  // R-type with rs2 x2, rs1 x1, rd x3
  function automatic logic [31:0] encode(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic [31:0] expected_result(int k, int r, int c);
    logic signed [31:0] acc;
    logic [31:0]        kw;
    logic [31:0]        iw;
    logic signed [7:0]  kb;
    logic signed [7:0]  ib;
    acc = 0;
    for (int i = 0; i < KERNEL_WIDTH; i++) begin
      for (int j = 0; j < KERNEL_WIDTH; j++) begin
        kw  = read_word(KERNEL_BASE + 32'((k * KW2 + i * KERNEL_WIDTH + j) * 4));
        iw  = read_word(IMAGE_BASE + 32'(((r + i) * IMAGE_WIDTH + c + j) * 4));
        kb  = kw[7:0];
        ib  = iw[7:0];
        acc = acc + kb * ib;
      end
    end
    return acc;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////
  always @(posedge nice_clk) begin
    if (nice_icb_cmd_valid && nice_icb_cmd_ready) begin
      if (!nice_icb_cmd_read) begin
        mem[nice_icb_cmd_addr] = nice_icb_cmd_wdata;
      end
      pend_addr.push_back(nice_icb_cmd_addr);
    end
    if (nice_icb_rsp_valid && nice_icb_rsp_ready) begin
      void'(pend_addr.pop_front());
    end
    if (nice_icb_cmd_valid) begin
      check_value("holdup during command", 32'd1, 32'(nice_mem_holdup));
    end
    #1;
    nice_icb_cmd_ready = stress ? ($urandom_range(3) != 0) : 1'b1;
    if (pend_addr.size() > 0 && (!stress || $urandom_range(2) == 0)) begin
      nice_icb_rsp_valid = 1'b1;
      nice_icb_rsp_rdata = read_word(pend_addr[0]);
      nice_icb_rsp_err   = (pend_addr[0] == err_addr);
    end else begin
      nice_icb_rsp_valid = 1'b0;
      nice_icb_rsp_err   = 1'b0;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic issue(string name, logic [31:0] inst, logic [31:0] rs1,
                       logic [31:0] exp_rdat, logic exp_err, bit no_bus);
    bit done;
    done = 1'b0;
    @(posedge nice_clk);
    #1;
    nice_req_valid = 1'b1;
    nice_req_inst  = inst;
    nice_req_rs1   = rs1;
    @(posedge nice_clk);
    while (!nice_req_ready) @(posedge nice_clk);
    check_value({name, " active on request"}, 32'd1, 32'(nice_active));
    #1;
    nice_req_valid = 1'b0;
    while (!done) begin
      @(posedge nice_clk);
      if (no_bus) begin
        check_value({name, " cmd_valid"}, 32'd0, 32'(nice_icb_cmd_valid));
      end
      if (nice_rsp_valid && nice_rsp_ready) begin
        check_value({name, " rdat"}, exp_rdat, nice_rsp_rdat);
        check_value({name, " err"}, 32'(exp_err), 32'(nice_rsp_err));
        done = 1'b1;
      end
      #1;
      nice_rsp_ready = stress ? ($urandom_range(1) == 1) : 1'b1;
    end
    // exactly one response per instruction
    @(posedge nice_clk);
    check_value({name, " single response"}, 32'd0, 32'(nice_rsp_valid));
  endtask

  task automatic fill_inputs();
    for (int n = 0; n < KERNEL_WORDS; n++) begin
      mem[KERNEL_BASE + 32'(n * 4)] = $urandom;
    end
    for (int n = 0; n < IMAGE_WORDS; n++) begin
      mem[IMAGE_BASE + 32'(n * 4)] = $urandom;
    end
    for (int n = 0; n < RESULT_WORDS; n++) begin
      mem.delete(RESULT_BASE + 32'(n * 4));
    end
  endtask

  task automatic check_results(string tag);
    int n;
    n = 0;
    for (int k = 0; k < KERNEL_NUM; k++) begin
      for (int r = 0; r < OUT_WIDTH; r++) begin
        for (int c = 0; c < OUT_WIDTH; c++) begin
          check_value($sformatf("%s result k%0d r%0d c%0d", tag, k, r, c),
                      expected_result(k, r, c), read_word(RESULT_BASE + 32'(n * 4)));
          n++;
        end
      end
    end
  endtask

  task automatic run_pass(int pass);
    string       tag;
    logic [31:0] ld_kernel;
    logic [31:0] ld_image;
    logic [31:0] conv;
    tag       = $sformatf("pass %0d", pass);
    ld_kernel = encode(nice_isa_pkg::F7_LOAD_KERNEL, nice_isa_pkg::F3_CONV,
                       nice_isa_pkg::OPC_CUSTOM3);
    ld_image  = encode(nice_isa_pkg::F7_LOAD_IMAGE, nice_isa_pkg::F3_CONV,
                       nice_isa_pkg::OPC_CUSTOM3);
    conv      = encode(nice_isa_pkg::F7_START_CONV, nice_isa_pkg::F3_CONV,
                       nice_isa_pkg::OPC_CUSTOM3);
    fill_inputs();
    // a plain add, then custom3 with an unknown func7
    issue({tag, " add"}, encode(7'h00, 3'b000, 7'b0110011), KERNEL_BASE, 0, 1'b1, 1'b1);
    issue({tag, " bad func7"}, encode(7'h7f, nice_isa_pkg::F3_CONV, nice_isa_pkg::OPC_CUSTOM3),
          KERNEL_BASE, 0, 1'b1, 1'b1);
    // one flagged read response, then a clean reload
    if (pass == 0) begin
      err_addr = KERNEL_BASE + 32'(7 * 4);
      issue({tag, " kernel bus error"}, ld_kernel, KERNEL_BASE, KERNEL_WORDS, 1'b1, 1'b0);
    end else begin
      err_addr = IMAGE_BASE + 32'(100 * 4);
      issue({tag, " image bus error"}, ld_image, IMAGE_BASE, IMAGE_WORDS, 1'b1, 1'b0);
    end
    err_addr = NO_ERR_ADDR;
    issue({tag, " load kernel"}, ld_kernel, KERNEL_BASE, KERNEL_WORDS, 1'b0, 1'b0);
    issue({tag, " load image"}, ld_image, IMAGE_BASE, IMAGE_WORDS, 1'b0, 1'b0);
    issue({tag, " convolve"}, conv, RESULT_BASE, RESULT_WORDS, 1'b0, 1'b0);
    check_results(tag);
  endtask

  task automatic check_idle_status(string name);
    check_value({name, " req_ready"}, 32'd1, 32'(nice_req_ready));
    check_value({name, " rsp_valid"}, 32'd0, 32'(nice_rsp_valid));
    check_value({name, " cmd_valid"}, 32'd0, 32'(nice_icb_cmd_valid));
    check_value({name, " active"}, 32'd0, 32'(nice_active));
    check_value({name, " holdup"}, 32'd0, 32'(nice_mem_holdup));
  endtask

  initial begin
    void'($urandom(32'h5a37ed99));
    nice_rst_n         = 1'b0;
    nice_req_valid     = 1'b0;
    nice_req_inst      = '0;
    nice_req_rs1       = '0;
    nice_rsp_ready     = 1'b1;
    nice_icb_cmd_ready = 1'b1;
    nice_icb_rsp_valid = 1'b0;
    nice_icb_rsp_rdata = '0;
    nice_icb_rsp_err   = 1'b0;
    err_addr           = NO_ERR_ADDR;
    stress             = 1'b0;
    repeat (4) @(posedge nice_clk);
    check_idle_status("in reset");
    repeat (4) @(posedge nice_clk);
    #1;
    nice_rst_n = 1'b1;
    @(posedge nice_clk);
    check_idle_status("after reset");
    for (int pass = 0; pass < 2; pass++) begin
      stress = (pass == 1);
      run_pass(pass);
    end
    $display("closing: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, uut.u_lsu.u_props.fail_count);
    if (errors == 0 && uut.u_lsu.u_props.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- bench/nice_conv_props.sv
// bus checks for the load/store unit; assumes rsp_ready tied high and in-order responses
`timescale 1ns/100ps

module nice_conv_props (
  input logic                nice_clk,
  input logic                nice_rst_n,
  input logic                nice_icb_cmd_valid,
  input logic                nice_icb_cmd_ready,
  input nice_isa_pkg::addr_t nice_icb_cmd_addr,
  input logic                nice_icb_cmd_read,
  input nice_isa_pkg::xlen_t nice_icb_cmd_wdata,
  input logic [1:0]          nice_icb_cmd_size,
  input logic                nice_icb_rsp_valid,
  input logic                nice_icb_rsp_ready
);

  int   fail_count = 0;
  int   outstanding;
  logic cmd_hsk;
  logic rsp_hsk;

  assign cmd_hsk = nice_icb_cmd_valid && nice_icb_cmd_ready;
  assign rsp_hsk = nice_icb_rsp_valid && nice_icb_rsp_ready;

  // commands accepted but not yet answered
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      outstanding <= 0;
    end else if (cmd_hsk && !rsp_hsk) begin
      outstanding <= outstanding + 1;
    end else if (rsp_hsk && !cmd_hsk) begin
      outstanding <= outstanding - 1;
    end
  end

  //////////////////////////////
  // command stability
  //////////////////////////////
  property cmd_held;
    @(posedge nice_clk) disable iff (!nice_rst_n)
      nice_icb_cmd_valid && !nice_icb_cmd_ready |=>
        nice_icb_cmd_valid && $stable(nice_icb_cmd_addr) &&
        $stable(nice_icb_cmd_read) && $stable(nice_icb_cmd_size);
  endproperty

  // write data only matters for stores
  property wdata_held;
    @(posedge nice_clk) disable iff (!nice_rst_n)
      nice_icb_cmd_valid && !nice_icb_cmd_ready && !nice_icb_cmd_read |=>
        $stable(nice_icb_cmd_wdata);
  endproperty

  property word_size;
    @(posedge nice_clk) disable iff (!nice_rst_n)
      nice_icb_cmd_valid |-> nice_icb_cmd_size == nice_isa_pkg::SIZE_WORD;
  endproperty

  property rsp_has_cmd;
    @(posedge nice_clk) disable iff (!nice_rst_n)
      nice_icb_rsp_valid |-> outstanding != 0;
  endproperty

  a_cmd_held: assert property (cmd_held) else begin
    $error("bus command changed or dropped while stalled");
    fail_count++;
  end

  a_wdata_held: assert property (wdata_held) else begin
    $error("store data changed while stalled");
    fail_count++;
  end

  a_word_size: assert property (word_size) else begin
    $error("bus command with a size other than one word");
    fail_count++;
  end

  a_rsp_has_cmd: assert property (rsp_has_cmd) else begin
    $error("bus response with no command outstanding");
    fail_count++;
  end

endmodule

//--- source/nice_conv_top.sv
// custom3 conv accelerator; the bus must answer every command, in order
`timescale 1ns/100ps

module nice_conv_top #(
  parameter int KERNEL_NUM   = 5,
  parameter int KERNEL_WIDTH = 3,
  parameter int IMAGE_WIDTH  = 14
) (
  input  logic                nice_clk,
  input  logic                nice_rst_n,
  output logic                nice_active,
  output logic                nice_mem_holdup,
  input  logic                nice_req_valid,
  output logic                nice_req_ready,
  input  nice_isa_pkg::xlen_t nice_req_inst,
  input  nice_isa_pkg::addr_t nice_req_rs1,
  output logic                nice_rsp_valid,
  input  logic                nice_rsp_ready,
  output nice_isa_pkg::xlen_t nice_rsp_rdat,
  output logic                nice_rsp_err,
  output logic                nice_icb_cmd_valid,
  input  logic                nice_icb_cmd_ready,
  output nice_isa_pkg::addr_t nice_icb_cmd_addr,
  output logic                nice_icb_cmd_read,
  output nice_isa_pkg::xlen_t nice_icb_cmd_wdata,
  output logic [1:0]          nice_icb_cmd_size,
  input  logic                nice_icb_rsp_valid,
  output logic                nice_icb_rsp_ready,
  input  nice_isa_pkg::xlen_t nice_icb_rsp_rdata,
  input  logic                nice_icb_rsp_err
);

  localparam int K_W = $clog2(KERNEL_NUM);
  localparam int P_W = $clog2(KERNEL_WIDTH * KERNEL_WIDTH);
  localparam int I_W = $clog2(IMAGE_WIDTH);

  logic                  op_start;
  nice_conv_pkg::op_t    op_kind;
  logic                  engine_start;
  logic                  op_done;
  logic                  rsp_err_seen;
  nice_isa_pkg::xlen_t   words_moved;
  logic                  result_valid;
  logic                  result_taken;
  nice_conv_pkg::acc_t   result_data;
  logic                  buf_wr_en;
  logic                  buf_wr_kernel;
  nice_conv_pkg::pixel_t buf_wr_data;
  logic [K_W-1:0]        kernel_rd_k;
  logic [P_W-1:0]        kernel_rd_pos;
  logic [I_W-1:0]        image_rd_row;
  logic [I_W-1:0]        image_rd_col;
  nice_conv_pkg::pixel_t kernel_rd_data;
  nice_conv_pkg::pixel_t image_rd_data;

  nice_ctrl u_ctrl (
    .nice_clk, .nice_rst_n,
    .nice_req_valid, .nice_req_ready, .nice_req_inst,
    .nice_rsp_valid, .nice_rsp_ready, .nice_rsp_rdat, .nice_rsp_err,
    .nice_active, .nice_mem_holdup,
    .op_start, .op_kind, .engine_start,
    .op_done, .rsp_err_seen, .words_moved
  );

  nice_lsu #(
    .KERNEL_NUM(KERNEL_NUM), .KERNEL_WIDTH(KERNEL_WIDTH), .IMAGE_WIDTH(IMAGE_WIDTH)
  ) u_lsu (
    .nice_clk, .nice_rst_n, .op_start, .op_kind, .nice_req_rs1,
    .nice_icb_cmd_valid, .nice_icb_cmd_ready, .nice_icb_cmd_addr,
    .nice_icb_cmd_read, .nice_icb_cmd_wdata, .nice_icb_cmd_size,
    .nice_icb_rsp_valid, .nice_icb_rsp_ready, .nice_icb_rsp_rdata, .nice_icb_rsp_err,
    .result_valid, .result_data, .result_taken,
    .buf_wr_en, .buf_wr_kernel, .buf_wr_data,
    .op_done, .rsp_err_seen, .words_moved
  );

  conv_buffers #(
    .KERNEL_NUM(KERNEL_NUM), .KERNEL_WIDTH(KERNEL_WIDTH), .IMAGE_WIDTH(IMAGE_WIDTH)
  ) u_buffers (
    .nice_clk, .nice_rst_n, .buf_wr_en, .buf_wr_kernel, .buf_wr_data,
    .kernel_rd_k, .kernel_rd_pos, .kernel_rd_data,
    .image_rd_row, .image_rd_col, .image_rd_data
  );

  conv_engine #(
    .KERNEL_NUM(KERNEL_NUM), .KERNEL_WIDTH(KERNEL_WIDTH), .IMAGE_WIDTH(IMAGE_WIDTH)
  ) u_engine (
    .nice_clk, .nice_rst_n, .engine_start, .result_taken,
    .kernel_rd_k, .kernel_rd_pos, .kernel_rd_data,
    .image_rd_row, .image_rd_col, .image_rd_data,
    .result_valid, .result_data
  );

endmodule

//--- source/conv_engine.sv
// valid-only convolution, stride 1; buffers must be loaded before engine_start
`timescale 1ns/100ps

module conv_engine #(
  parameter int  KERNEL_NUM   = 5,
  parameter int  KERNEL_WIDTH = 3,
  parameter int  IMAGE_WIDTH  = 14,
  localparam int OUT_WIDTH    = IMAGE_WIDTH - KERNEL_WIDTH + 1,
  localparam int K_W          = $clog2(KERNEL_NUM),
  localparam int P_W          = $clog2(KERNEL_WIDTH * KERNEL_WIDTH),
  localparam int I_W          = $clog2(IMAGE_WIDTH),
  localparam int W_W          = $clog2(KERNEL_WIDTH),
  localparam int O_W          = $clog2(OUT_WIDTH)
) (
  input  logic                  nice_clk,
  input  logic                  nice_rst_n,
  input  logic                  engine_start,
  input  logic                  result_taken,
  output logic [K_W-1:0]        kernel_rd_k,
  output logic [P_W-1:0]        kernel_rd_pos,
  input  nice_conv_pkg::pixel_t kernel_rd_data,
  output logic [I_W-1:0]        image_rd_row,
  output logic [I_W-1:0]        image_rd_col,
  input  nice_conv_pkg::pixel_t image_rd_data,
  output logic                  result_valid,
  output nice_conv_pkg::acc_t   result_data
);

  logic                busy;
  logic [K_W-1:0]      k_q;
  logic [O_W-1:0]      row_q;
  logic [O_W-1:0]      col_q;
  logic [W_W-1:0]      wi_q;
  logic [W_W-1:0]      wj_q;
  logic                step;
  logic                take;
  nice_conv_pkg::acc_t acc_q;
  nice_conv_pkg::acc_t product;

  // one window element per cycle and no step while a sum waits
  assign step = busy && !result_valid;
  assign take = result_valid && result_taken;

  assign kernel_rd_k   = k_q;
  assign kernel_rd_pos = P_W'(wi_q * KERNEL_WIDTH + wj_q);
  assign image_rd_row  = I_W'(row_q) + I_W'(wi_q);
  assign image_rd_col  = I_W'(col_q) + I_W'(wj_q);

  assign product = nice_conv_pkg::acc_t'(kernel_rd_data) * nice_conv_pkg::acc_t'(image_rd_data);

  //////////////////////////////
  // window and output walk
  //////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      busy         <= 1'b0;
      result_valid <= 1'b0;
      k_q          <= '0;
      row_q        <= '0;
      col_q        <= '0;
      wi_q         <= '0;
      wj_q         <= '0;
    end else if (engine_start) begin
      busy         <= 1'b1;
      result_valid <= 1'b0;
      k_q          <= '0;
      row_q        <= '0;
      col_q        <= '0;
      wi_q         <= '0;
      wj_q         <= '0;
    end else if (step) begin
      if (wj_q == W_W'(KERNEL_WIDTH - 1)) begin
        wj_q <= '0;
        if (wi_q == W_W'(KERNEL_WIDTH - 1)) begin
          wi_q         <= '0;
          result_valid <= 1'b1;
        end else begin
          wi_q <= wi_q + 1'b1;
        end
      end else begin
        wj_q <= wj_q + 1'b1;
      end
    end else if (take) begin
      result_valid <= 1'b0;
      // column, then row, then kernel
      if (col_q == O_W'(OUT_WIDTH - 1)) begin
        col_q <= '0;
        if (row_q == O_W'(OUT_WIDTH - 1)) begin
          row_q <= '0;
          if (k_q == K_W'(KERNEL_NUM - 1)) begin
            k_q  <= '0;
            busy <= 1'b0;
          end else begin
            k_q <= k_q + 1'b1;
          end
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // accumulator cleared for every new window
  always_ff @(posedge nice_clk) begin
    if (engine_start || take) begin
      acc_q <= '0;
    end else if (step) begin
      acc_q <= acc_q + product;
    end
  end

  assign result_data = acc_q;

endmodule

//--- source/conv_buffers.sv
// write indices wrap when full, so a reload must bring a complete set of words
`timescale 1ns/100ps

module conv_buffers #(
  parameter int  KERNEL_NUM   = 5,
  parameter int  KERNEL_WIDTH = 3,
  parameter int  IMAGE_WIDTH  = 14,
  localparam int KW2          = KERNEL_WIDTH * KERNEL_WIDTH,
  localparam int K_W          = $clog2(KERNEL_NUM),
  localparam int P_W          = $clog2(KW2),
  localparam int I_W          = $clog2(IMAGE_WIDTH)
) (
  input  logic                  nice_clk,
  input  logic                  nice_rst_n,
  input  logic                  buf_wr_en,
  input  logic                  buf_wr_kernel,
  input  nice_conv_pkg::pixel_t buf_wr_data,
  input  logic [K_W-1:0]        kernel_rd_k,
  input  logic [P_W-1:0]        kernel_rd_pos,
  output nice_conv_pkg::pixel_t kernel_rd_data,
  input  logic [I_W-1:0]        image_rd_row,
  input  logic [I_W-1:0]        image_rd_col,
  output nice_conv_pkg::pixel_t image_rd_data
);

  nice_conv_pkg::pixel_t kernel_mem [KERNEL_NUM][KW2];
  nice_conv_pkg::pixel_t image_mem  [IMAGE_WIDTH][IMAGE_WIDTH];

  logic [K_W-1:0] wr_k;
  logic [P_W-1:0] wr_pos;
  logic [I_W-1:0] wr_row;
  logic [I_W-1:0] wr_col;
  logic           kernel_we;
  logic           image_we;

  assign kernel_we = buf_wr_en && buf_wr_kernel;
  assign image_we  = buf_wr_en && !buf_wr_kernel;

  //////////////////////////////
  // write indices
  //////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      wr_k   <= '0;
      wr_pos <= '0;
      wr_row <= '0;
      wr_col <= '0;
    end else begin
      // kernel then position
      if (kernel_we) begin
        if (wr_pos == P_W'(KW2 - 1)) begin
          wr_pos <= '0;
          wr_k   <= (wr_k == K_W'(KERNEL_NUM - 1)) ? '0 : wr_k + 1'b1;
        end else begin
          wr_pos <= wr_pos + 1'b1;
        end
      end
      // row then column
      if (image_we) begin
        if (wr_col == I_W'(IMAGE_WIDTH - 1)) begin
          wr_col <= '0;
          wr_row <= (wr_row == I_W'(IMAGE_WIDTH - 1)) ? '0 : wr_row + 1'b1;
        end else begin
          wr_col <= wr_col + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge nice_clk) begin
    if (kernel_we) begin
      kernel_mem[wr_k][wr_pos] <= buf_wr_data;
    end
    if (image_we) begin
      image_mem[wr_row][wr_col] <= buf_wr_data;
    end
  end

  // read ports for the engine
  assign kernel_rd_data = kernel_mem[kernel_rd_k][kernel_rd_pos];
  assign image_rd_data  = image_mem[image_rd_row][image_rd_col];

endmodule

//--- source/nice_lsu.sv
// responses must return in command order; commands may run ahead of responses
`timescale 1ns/100ps

module nice_lsu #(
  parameter int KERNEL_NUM   = 5,
  parameter int KERNEL_WIDTH = 3,
  parameter int IMAGE_WIDTH  = 14
) (
  input  logic                  nice_clk,
  input  logic                  nice_rst_n,
  input  logic                  op_start,
  input  nice_conv_pkg::op_t    op_kind,
  input  nice_isa_pkg::addr_t   nice_req_rs1,
  output logic                  nice_icb_cmd_valid,
  input  logic                  nice_icb_cmd_ready,
  output nice_isa_pkg::addr_t   nice_icb_cmd_addr,
  output logic                  nice_icb_cmd_read,
  output nice_isa_pkg::xlen_t   nice_icb_cmd_wdata,
  output logic [1:0]            nice_icb_cmd_size,
  input  logic                  nice_icb_rsp_valid,
  output logic                  nice_icb_rsp_ready,
  input  nice_isa_pkg::xlen_t   nice_icb_rsp_rdata,
  input  logic                  nice_icb_rsp_err,
  input  logic                  result_valid,
  input  nice_conv_pkg::acc_t   result_data,
  output logic                  result_taken,
  output logic                  buf_wr_en,
  output logic                  buf_wr_kernel,
  output nice_conv_pkg::pixel_t buf_wr_data,
  output logic                  op_done,
  output logic                  rsp_err_seen,
  output nice_isa_pkg::xlen_t   words_moved
);

  localparam int OUT_WIDTH    = IMAGE_WIDTH - KERNEL_WIDTH + 1;
  localparam int KERNEL_WORDS = KERNEL_NUM * KERNEL_WIDTH * KERNEL_WIDTH;
  localparam int IMAGE_WORDS  = IMAGE_WIDTH * IMAGE_WIDTH;
  localparam int RESULT_WORDS = KERNEL_NUM * OUT_WIDTH * OUT_WIDTH;

  nice_conv_pkg::op_t  kind_q;
  nice_isa_pkg::addr_t addr_q;
  nice_isa_pkg::xlen_t total_sel;
  nice_isa_pkg::xlen_t total_q;
  nice_isa_pkg::xlen_t cmd_cnt;
  nice_isa_pkg::xlen_t rsp_cnt;
  logic                active;
  logic                is_write;
  logic                cmd_hsk;
  logic                rsp_hsk;

  always_comb begin
    case (op_kind)
      nice_conv_pkg::OP_READ_KERNEL:  total_sel = nice_isa_pkg::xlen_t'(KERNEL_WORDS);
      nice_conv_pkg::OP_READ_IMAGE:   total_sel = nice_isa_pkg::xlen_t'(IMAGE_WORDS);
      nice_conv_pkg::OP_WRITE_RESULT: total_sel = nice_isa_pkg::xlen_t'(RESULT_WORDS);
      default:                        total_sel = '0;
    endcase
  end

  assign is_write = (kind_q == nice_conv_pkg::OP_WRITE_RESULT);
  assign cmd_hsk  = nice_icb_cmd_valid && nice_icb_cmd_ready;
  assign rsp_hsk  = nice_icb_rsp_valid && nice_icb_rsp_ready && active;

  //////////////////////////////
  // command side
  //////////////////////////////

  // stores wait for the engine to hold a finished sum
  assign nice_icb_cmd_valid = active && (cmd_cnt != total_q) && (!is_write || result_valid);
  assign nice_icb_cmd_addr  = addr_q;
  assign nice_icb_cmd_read  = !is_write;
  assign nice_icb_cmd_wdata = nice_isa_pkg::xlen_t'(result_data);
  assign nice_icb_cmd_size  = nice_isa_pkg::SIZE_WORD;
  assign result_taken       = cmd_hsk && is_write;

  always_ff @(posedge nice_clk) begin
    if (op_start) begin
      addr_q <= nice_req_rs1;
    end else if (cmd_hsk) begin
      addr_q <= addr_q + nice_isa_pkg::addr_t'(nice_isa_pkg::WORD_BYTES);
    end
  end

  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      kind_q  <= nice_conv_pkg::OP_NONE;
      total_q <= '0;
      cmd_cnt <= '0;
      rsp_cnt <= '0;
      active  <= 1'b0;
    end else if (op_start) begin
      kind_q  <= op_kind;
      total_q <= total_sel;
      cmd_cnt <= '0;
      rsp_cnt <= '0;
      active  <= 1'b1;
    end else begin
      if (cmd_hsk) begin
        cmd_cnt <= cmd_cnt + 1'b1;
      end
      if (rsp_hsk) begin
        rsp_cnt <= rsp_cnt + 1'b1;
        if (op_done) begin
          active <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////
  // response side
  //////////////////////////////
  assign nice_icb_rsp_ready = 1'b1;
  assign op_done            = rsp_hsk && (rsp_cnt == total_q - 1'b1);
  assign rsp_err_seen       = rsp_hsk && nice_icb_rsp_err;
  assign words_moved        = rsp_cnt;

  // only the low byte of a loaded word is kept
  assign buf_wr_en     = rsp_hsk && !is_write;
  assign buf_wr_kernel = (kind_q == nice_conv_pkg::OP_READ_KERNEL);
  assign buf_wr_data   = nice_conv_pkg::pixel_t'(nice_icb_rsp_rdata[7:0]);

endmodule

//--- source/nice_ctrl.sv
// one instruction at a time; unsupported instructions are answered with err and rdat zero
`timescale 1ns/100ps

module nice_ctrl (
  input  logic                nice_clk,
  input  logic                nice_rst_n,
  input  logic                nice_req_valid,
  output logic                nice_req_ready,
  input  nice_isa_pkg::xlen_t nice_req_inst,
  output logic                nice_rsp_valid,
  input  logic                nice_rsp_ready,
  output nice_isa_pkg::xlen_t nice_rsp_rdat,
  output logic                nice_rsp_err,
  output logic                nice_active,
  output logic                nice_mem_holdup,
  output logic                op_start,
  output nice_conv_pkg::op_t  op_kind,
  output logic                engine_start,
  input  logic                op_done,
  input  logic                rsp_err_seen,
  input  nice_isa_pkg::xlen_t words_moved
);

  nice_isa_pkg::opcode_t       opcode;
  nice_isa_pkg::funct3_t       funct3;
  nice_isa_pkg::funct7_t       funct7;
  nice_conv_pkg::ctrl_state_t  state;
  nice_conv_pkg::ctrl_state_t  state_nxt;
  logic                        conv_group;
  logic                        is_load_kernel;
  logic                        is_load_image;
  logic                        is_start_conv;
  logic                        is_supported;
  logic                        req_hsk;
  logic                        err_q;
  logic                        illegal_q;

  //////////////////////////////
  // decode
  //////////////////////////////
  assign opcode = nice_req_inst[6:0];
  assign funct3 = nice_req_inst[14:12];
  assign funct7 = nice_req_inst[31:25];

  assign conv_group     = (opcode == nice_isa_pkg::OPC_CUSTOM3) &&
                          (funct3 == nice_isa_pkg::F3_CONV);
  assign is_load_kernel = conv_group && (funct7 == nice_isa_pkg::F7_LOAD_KERNEL);
  assign is_load_image  = conv_group && (funct7 == nice_isa_pkg::F7_LOAD_IMAGE);
  assign is_start_conv  = conv_group && (funct7 == nice_isa_pkg::F7_START_CONV);
  assign is_supported   = is_load_kernel || is_load_image || is_start_conv;

  assign nice_req_ready = (state == nice_conv_pkg::ST_IDLE);
  assign req_hsk        = nice_req_valid && nice_req_ready;

  // handed to the bus unit in the accept cycle
  assign op_start     = req_hsk && is_supported;
  assign engine_start = req_hsk && is_start_conv;

  always_comb begin
    op_kind = nice_conv_pkg::OP_NONE;
    if (is_load_kernel) begin
      op_kind = nice_conv_pkg::OP_READ_KERNEL;
    end else if (is_load_image) begin
      op_kind = nice_conv_pkg::OP_READ_IMAGE;
    end else if (is_start_conv) begin
      op_kind = nice_conv_pkg::OP_WRITE_RESULT;
    end
  end

  //////////////////////////////
  // FSM
  //////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      nice_conv_pkg::ST_IDLE: begin
        if (req_hsk) begin
          if (is_load_kernel) begin
            state_nxt = nice_conv_pkg::ST_LOAD_KERNEL;
          end else if (is_load_image) begin
            state_nxt = nice_conv_pkg::ST_LOAD_IMAGE;
          end else if (is_start_conv) begin
            state_nxt = nice_conv_pkg::ST_CONVOLVE;
          end else begin
            state_nxt = nice_conv_pkg::ST_RESPOND;
          end
        end
      end
      nice_conv_pkg::ST_LOAD_KERNEL,
      nice_conv_pkg::ST_LOAD_IMAGE,
      nice_conv_pkg::ST_CONVOLVE: begin
        if (op_done) begin
          state_nxt = nice_conv_pkg::ST_RESPOND;
        end
      end
      nice_conv_pkg::ST_RESPOND: begin
        if (nice_rsp_ready) begin
          state_nxt = nice_conv_pkg::ST_IDLE;
        end
      end
      default: state_nxt = nice_conv_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      state     <= nice_conv_pkg::ST_IDLE;
      err_q     <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (req_hsk) begin
        err_q     <= !is_supported;
        illegal_q <= !is_supported;
      end else if (rsp_err_seen) begin
        // sticky until the next instruction
        err_q <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // response and status
  //////////////////////////////
  assign nice_rsp_valid = (state == nice_conv_pkg::ST_RESPOND);
  assign nice_rsp_err   = err_q;
  // count stays put in the bus unit until its next operation
  assign nice_rsp_rdat  = illegal_q ? '0 : words_moved;

  assign nice_active     = (state == nice_conv_pkg::ST_IDLE) ? nice_req_valid : 1'b1;
  assign nice_mem_holdup = (state == nice_conv_pkg::ST_LOAD_KERNEL) ||
                           (state == nice_conv_pkg::ST_LOAD_IMAGE)  ||
                           (state == nice_conv_pkg::ST_CONVOLVE);

endmodule

//--- source/nice_conv_pkg.sv
// elements are the signed low byte of each memory word; sums wrap at 32 bits
package nice_conv_pkg;

  //////////////////////////////
  // data types
  //////////////////////////////

  // one kernel weight or image pixel
  typedef logic signed [7:0] pixel_t;

  // convolution sum and the stored result word
  typedef logic signed [31:0] acc_t;

  //////////////////////////////
  // controller and bus unit
  //////////////////////////////

  // controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD_KERNEL,
    ST_LOAD_IMAGE,
    ST_CONVOLVE,
    ST_RESPOND
  } ctrl_state_t;

  // operation run by the load/store unit
  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ_KERNEL,
    OP_READ_IMAGE,
    OP_WRITE_RESULT
  } op_t;

endpackage

//--- source/nice_isa_pkg.sv
// RV32 R-type custom3 decode only; word transfers of 32 bits on a 32-bit address bus
package nice_isa_pkg;

  //////////////////////////////
  // core and bus widths
  //////////////////////////////
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;

  // R-type instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  //////////////////////////////
  // custom3 encodings
  //////////////////////////////
  localparam opcode_t OPC_CUSTOM3 = 7'b1111011;

  // all three instructions share one func3
  localparam funct3_t F3_CONV = 3'b010;

  // func7 picks the instruction
  localparam funct7_t F7_LOAD_KERNEL = 7'b0001011;
  localparam funct7_t F7_LOAD_IMAGE  = 7'b0001111;
  localparam funct7_t F7_START_CONV  = 7'b0010000;

  // bus transfer details
  localparam int         WORD_BYTES = 4;
  localparam logic [1:0] SIZE_WORD  = 2'b10;

endpackage
